//--- hw/sdInitPkg.sv
`default_nettype none

package sdInitPkg;

	// Timing and limits
	localparam int SpiHalfPeriod = 4; // Clk cycles per SPI clock half period
	localparam int PowerUpCycles = 256; // Kept short so simulation stays quick
	localparam int DummyBytes = 10; // 80 SPI clocks with chip select high
	localparam int ResponsePolls = 8; // Card answers within 8 bytes or counts as silent
	localparam int MaxInitRetries = 16;

	// Command indices used during start-up
	localparam logic [5:0] CmdGoIdle = 6'd0;
	localparam logic [5:0] CmdSendIfCond = 6'd8;
	localparam logic [5:0] CmdAppCmd = 6'd55;
	localparam logic [5:0] AcmdSendOpCond = 6'd41;

	// Voltage range 2.7-3.6 V in bits 11:8, check pattern in the low byte
	localparam logic [31:0] IfCondArgument = 32'h0000_01AA;
	localparam logic [31:0] OpCondArgument = 32'h4000_0000; // HCS bit, host supports SDHC

	typedef struct packed {
		logic [5:0] index;
		logic [31:0] argument;
	} sdCommand_t;

	// One byte for the shifter together with the chip select level to drive while it shifts
	typedef struct packed {
		logic [7:0] data;
		logic chipSelect; // Low selects the card
	} spiByte_t;

	typedef struct packed {
		logic ready;
		logic failed;
	} sdStatus_t;

endpackage

`default_nettype wire

//--- hw/spiByteShifter.sv
`timescale 1ns/1ps
`default_nettype none

module spiByteShifter
	import sdInitPkg::*;
(
	input wire clk,
	input wire reset,
	input wire spiByte_t txByte,
	input wire txValid,
	output logic txReady,
	output logic [7:0] rxByte,
	output logic rxValid,
	output logic sdSck,
	output logic sdCs,
	output logic sdMosi,
	input wire sdMiso
);

	localparam int DivWidth = $clog2(SpiHalfPeriod);

	logic [DivWidth-1:0] divCount; // Position inside the current half period
	logic [3:0] phase; // Even phases have sdSck low, odd ones high
	logic busy;
	logic halfDone;
	logic misoBit; // MISO captured on the rising edge, shifted in on the falling one
	logic [7:0] shiftReg;

	assign txReady = !busy;
	assign halfDone = divCount == DivWidth'(SpiHalfPeriod - 1);
	assign sdMosi = busy ? shiftReg[7] : 1'b1; // Line idles high between bytes
	assign rxByte = shiftReg;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			divCount <= '0;
			phase <= '0;
			sdSck <= 1'b0;
			sdCs <= 1'b1;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			if (txValid && !busy) begin
				busy <= 1'b1;
				sdCs <= txByte.chipSelect;
				divCount <= '0;
				phase <= '0;
			end else if (busy) begin
				divCount <= halfDone ? '0 : divCount + 1'b1;
				if (halfDone) begin
					phase <= phase + 1'b1;
					sdSck <= !phase[0];
					// Falling edge after the eighth high phase closes the byte
					if (phase == 4'd15) begin
						busy <= 1'b0;
						rxValid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (txValid && !busy) begin
			shiftReg <= txByte.data;
		end else if (busy && halfDone) begin
			if (!phase[0])
				misoBit <= sdMiso; // Rising SPI edge
			else
				shiftReg <= {shiftReg[6:0], misoBit}; // Falling edge moves the next bit out
		end
	end

	// A waiting byte must not change under the shifter
	assert property (@(posedge clk) disable iff (reset)
		txValid && !txReady |=> txValid && $stable(txByte))
		else $error("txByte changed or was withdrawn before the shifter took it");

endmodule

`default_nettype wire

//--- hw/sdCommandFramer.sv
`timescale 1ns/1ps
`default_nettype none

module sdCommandFramer
	import sdInitPkg::*;
(
	input wire clk,
	input wire reset,
	input wire sdCommand_t cmd,
	input wire cmdValid,
	output logic cmdReady,
	output spiByte_t txByte,
	output logic txValid,
	input wire txReady
);

	logic busy;
	logic [2:0] byteCount; // Byte on offer, 5 is the CRC trailer
	logic lastByte;
	logic [39:0] newFrame;
	logic [39:0] frame; // Bytes still to go, next one in the top byte
	logic [39:0] crcFeed;
	logic [5:0] crcBits; // Frame bits not yet folded into the CRC
	logic [6:0] crc;
	logic crcFeedback;

	// Start bit 0, transmission bit 1, then index and argument
	assign newFrame = {2'b01, cmd.index, cmd.argument};

	assign cmdReady = !busy;
	assign lastByte = byteCount == 3'd5;
	// The trailer waits for the CRC, although the shifter is far slower anyway
	assign txValid = busy && !(lastByte && crcBits != 6'd0);
	assign txByte.data = lastByte ? {crc, 1'b1} : frame[39:32];
	assign txByte.chipSelect = 1'b0;
	assign crcFeedback = crc[6] ^ crcFeed[39];

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			byteCount <= '0;
			crcBits <= '0;
		end else if (cmdValid && !busy) begin
			busy <= 1'b1;
			byteCount <= '0;
			crcBits <= 6'd40;
		end else begin
			if (txValid && txReady) begin
				byteCount <= byteCount + 1'b1;
				if (lastByte)
					busy <= 1'b0;
			end
			if (crcBits != 6'd0)
				crcBits <= crcBits - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cmdValid && !busy) begin
			frame <= newFrame;
			crcFeed <= newFrame;
			crc <= '0;
		end else begin
			if (txValid && txReady)
				frame <= {frame[31:0], 8'h00};
			if (crcBits != 6'd0) begin
				// CRC7, polynomial x^7 + x^3 + 1, one frame bit per clk
				crc <= {crc[5:0], 1'b0} ^ (crcFeedback ? 7'h09 : 7'h00);
				crcFeed <= {crcFeed[38:0], 1'b0};
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		cmdValid && !cmdReady |=> cmdValid && $stable(cmd))
		else $error("Command request dropped or changed before acceptance");

endmodule

`default_nettype wire

//--- hw/sdInitSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sdInitSequencer
	import sdInitPkg::*;
(
	input wire clk,
	input wire reset,
	input wire cardAbsent,
	output sdCommand_t cmd,
	output logic cmdValid,
	input wire cmdReady,
	output spiByte_t seqByte,
	output logic seqValid,
	input wire seqReady,
	input wire frameBusy,
	input wire [7:0] rxByte,
	input wire rxValid,
	output sdStatus_t status
);

	typedef enum logic [2:0] {
		PowerUp, DummyClocks, SendCommand, AwaitResponse,
		ReadTail, TrailByte, CardReady, CardFailed
	} state_t;

	// Which command of the start-up sequence is current
	typedef enum logic [1:0] {StageGoIdle, StageIfCond, StageAppCmd, StageOpCond} stage_t;

	localparam int CountWidth = $clog2(PowerUpCycles);
	localparam int RetryWidth = $clog2(MaxInitRetries);

	state_t state;
	stage_t stage;
	logic [CountWidth-1:0] count; // Cycles, dummy bytes, polls or R7 bytes, per state
	logic [RetryWidth-1:0] retries;
	logic pending; // One of our own bytes sits in the shifter
	logic ownByte;
	logic finishReady;
	logic finishFail;
	logic responseOk;
	logic [7:0] prevByte;

	// Bytes echoed while the framer streams a command are not ours and are dropped
	assign ownByte = rxValid && pending;
	assign seqValid = (state inside {DummyClocks, AwaitResponse, ReadTail, TrailByte})
		&& !pending && !frameBusy;
	assign seqByte.data = 8'hFF;
	assign seqByte.chipSelect = state == DummyClocks || state == TrailByte;
	assign cmdValid = state == SendCommand;
	assign status.ready = state == CardReady;
	assign status.failed = state == CardFailed;

	always_comb begin
		case (stage)
			StageGoIdle: cmd = '{index: CmdGoIdle, argument: 32'h0};
			StageIfCond: cmd = '{index: CmdSendIfCond, argument: IfCondArgument};
			StageAppCmd: cmd = '{index: CmdAppCmd, argument: 32'h0};
			default: cmd = '{index: AcmdSendOpCond, argument: OpCondArgument};
		endcase
	end

	// An idle reply to ACMD41 only passes the R1 check while retries remain
	always_comb begin
		case (stage)
			StageGoIdle, StageIfCond: responseOk = rxByte == 8'h01;
			StageAppCmd: responseOk = rxByte == 8'h00 || rxByte == 8'h01;
			default: responseOk = rxByte == 8'h00
				|| (rxByte == 8'h01 && retries != RetryWidth'(MaxInitRetries - 1));
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || cardAbsent) begin
			state <= PowerUp;
			stage <= StageGoIdle;
			count <= '0;
			retries <= '0;
			pending <= 1'b0;
			finishReady <= 1'b0;
			finishFail <= 1'b0;
		end else begin
			if (seqValid && seqReady)
				pending <= 1'b1;
			else if (ownByte)
				pending <= 1'b0;
			case (state)
				PowerUp: begin
					count <= count + 1'b1;
					if (count == CountWidth'(PowerUpCycles - 1)) begin
						count <= '0;
						state <= DummyClocks;
					end
				end
				DummyClocks: if (ownByte) begin
					count <= count + 1'b1;
					if (count == CountWidth'(DummyBytes - 1)) begin
						count <= '0;
						state <= SendCommand;
					end
				end
				SendCommand: if (cmdReady) state <= AwaitResponse; // Framer takes it now
				AwaitResponse: if (ownByte) begin
					count <= count + 1'b1;
					if (!rxByte[7]) begin // Start of R1
						count <= '0;
						finishFail <= !responseOk;
						state <= (responseOk && stage == StageIfCond) ? ReadTail : TrailByte;
						if (responseOk) begin
							case (stage)
								StageGoIdle: stage <= StageIfCond;
								StageAppCmd: stage <= StageOpCond;
								StageOpCond: begin
									finishReady <= rxByte == 8'h00;
									retries <= retries + 1'b1;
									stage <= StageAppCmd;
								end
								default: stage <= stage;
							endcase
						end
					end else if (count == CountWidth'(ResponsePolls - 1)) begin
						finishFail <= 1'b1; // Card stayed silent
						state <= TrailByte;
					end
				end
				ReadTail: if (ownByte) begin
					count <= count + 1'b1;
					if (count == CountWidth'(3)) begin
						count <= '0;
						finishFail <= {prevByte, rxByte} != 16'h01AA;
						stage <= StageAppCmd;
						state <= TrailByte;
					end
				end
				TrailByte: if (ownByte)
					state <= finishFail ? CardFailed : finishReady ? CardReady : SendCommand;
				default: state <= state; // Outcome holds until the card is pulled
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ReadTail && ownByte)
			prevByte <= rxByte;
	end

	assert property (@(posedge clk) disable iff (reset || cardAbsent)
		!(finishReady && finishFail))
		else $error("Ready and failed verdicts were both set");

	// An outcome only clears through reset or card removal
	assert property (@(posedge clk) disable iff (reset)
		(status.ready || status.failed) && !cardAbsent |=> $stable(status))
		else $error("Status changed while the card stayed inserted");

endmodule

`default_nettype wire

//--- hw/sdInitTop.sv
`timescale 1ns/1ps
`default_nettype none

module sdInitTop
	import sdInitPkg::*;
(
	input wire clk,
	input wire reset,
	input wire cardAbsent,
	input wire hostSck,
	input wire hostCs,
	input wire hostMosi,
	output logic hostMiso,
	output logic sdSck,
	output logic sdCs,
	output logic sdMosi,
	input wire sdMiso,
	output sdStatus_t status
);

	logic coreReset;
	sdCommand_t cmd;
	logic cmdValid;
	logic cmdReady;
	spiByte_t frameByte;
	spiByte_t seqByte;
	spiByte_t txByte;
	logic frameValid;
	logic seqValid;
	logic txValid;
	logic txReady;
	logic frameBusy;
	logic [7:0] rxByte;
	logic rxValid;
	logic coreSck;
	logic coreCs;
	logic coreMosi;

	assign coreReset = reset || cardAbsent; // Pulling the card aborts any byte in flight
	assign frameBusy = !cmdReady;

	// The framer owns the shifter for the whole command, the sequencer otherwise
	assign txByte = frameBusy ? frameByte : seqByte;
	assign txValid = frameBusy ? frameValid : seqValid;

	// After a good start-up the host drives the card directly
	assign sdSck = status.ready ? hostSck : coreSck;
	assign sdCs = status.ready ? hostCs : coreCs;
	assign sdMosi = status.ready ? hostMosi : coreMosi;
	assign hostMiso = sdMiso;

	spiByteShifter shifter (
		.clk(clk), .reset(coreReset), .txByte(txByte), .txValid(txValid),
		.txReady(txReady), .rxByte(rxByte), .rxValid(rxValid),
		.sdSck(coreSck), .sdCs(coreCs), .sdMosi(coreMosi), .sdMiso(sdMiso)
	);

	sdCommandFramer framer (
		.clk(clk), .reset(coreReset), .cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
		.txByte(frameByte), .txValid(frameValid), .txReady(txReady && frameBusy)
	);

	sdInitSequencer sequencer (
		.clk(clk), .reset(reset), .cardAbsent(cardAbsent),
		.cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
		.seqByte(seqByte), .seqValid(seqValid), .seqReady(txReady && !frameBusy),
		.frameBusy(frameBusy), .rxByte(rxByte), .rxValid(rxValid), .status(status)
	);

endmodule

`default_nettype wire

//--- verification/sdCardModel.sv
`timescale 1ns/1ps
`default_nettype none

// SPI-mode card that answers the start-up commands and counts what it receives
module sdCardModel (
	input wire cardAbsent, // Rising edge acts as a fresh insertion
	input wire badEcho, // R7 returns a wrong check pattern
	input wire silent, // Card never answers
	input wire [7:0] busyRounds, // ACMD41 replies that still report idle
	input wire sdSck,
	input wire sdCs,
	input wire sdMosi,
	output logic sdMiso,
	output int cmd0Count,
	output int cmd8Count,
	output int cmd55Count,
	output int acmd41Count,
	output int crcErrors,
	output int preClocks // SPI clocks with chip select high before the first CMD0
);

	logic [7:0] inShift = 8'hFF;
	logic [7:0] outShift = 8'hFF;
	logic [47:0] frame = '0; // Last six command bytes, trailer in the low byte
	logic inIdle = 1'b0;
	int bitCount = 0;
	int frameBytes = 0;
	int busyLeft = 0;
	logic [7:0] replies [$];

	assign sdMiso = sdCs ? 1'b1 : outShift[7];

	// CRC7 with polynomial x^7 + x^3 + 1, MSB of the frame first
	function automatic logic [6:0] crc7(input logic [39:0] bits);
		logic [6:0] crc;
		logic feedback;
		crc = '0;
		for (int i = 39; i >= 0; i--) begin
			feedback = crc[6] ^ bits[i];
			crc = {crc[5:0], 1'b0} ^ (feedback ? 7'h09 : 7'h00);
		end
		return crc;
	endfunction

	task automatic answerCommand();
		logic [7:0] r1;
		if (frame[7:0] != {crc7(frame[47:8]), 1'b1})
			crcErrors++;
		case (frame[45:40])
			6'd0: begin
				cmd0Count++;
				inIdle = 1'b1;
				r1 = 8'h01;
			end
			6'd8: begin
				cmd8Count++;
				r1 = 8'h01;
			end
			6'd55: begin
				cmd55Count++;
				r1 = {7'd0, inIdle};
			end
			6'd41: begin
				acmd41Count++;
				if (busyLeft > 0)
					busyLeft--;
				else
					inIdle = 1'b0; // Initialization finished
				r1 = {7'd0, inIdle};
			end
			default: r1 = 8'h04; // Illegal command
		endcase
		if (!silent) begin
			replies.push_back(8'hFF); // One byte of response delay
			replies.push_back(r1);
			if (frame[45:40] == 6'd8) begin
				// R7 tail echoes the voltage range and the check pattern
				replies.push_back(8'h00);
				replies.push_back(8'h00);
				replies.push_back(8'h01);
				replies.push_back(badEcho ? 8'h55 : 8'hAA);
			end
		end
	endtask

	task automatic takeByte(input logic [7:0] data);
		// Between commands only a byte starting with 01 opens a frame
		if (frameBytes != 0 || data[7:6] == 2'b01) begin
			frame = {frame[39:0], data};
			frameBytes++;
			if (frameBytes == 6) begin
				frameBytes = 0;
				answerCommand();
			end
		end
	endtask

	always @(posedge sdSck or negedge sdSck or posedge cardAbsent) begin
		if (cardAbsent) begin
			cmd0Count = 0;
			cmd8Count = 0;
			cmd55Count = 0;
			acmd41Count = 0;
			crcErrors = 0;
			preClocks = 0;
			bitCount = 0;
			frameBytes = 0;
			inIdle = 1'b0;
			busyLeft = int'(busyRounds);
			outShift = 8'hFF;
			replies.delete();
		end else if (sdSck) begin
			if (sdCs) begin
				if (cmd0Count == 0)
					preClocks++;
			end else begin
				inShift = {inShift[6:0], sdMosi}; // Mode 0 samples on the rising edge
				bitCount++;
			end
		end else if (!sdCs) begin
			if (bitCount == 8) begin
				bitCount = 0;
				takeByte(inShift);
				if (replies.size() != 0)
					outShift = replies.pop_front();
				else
					outShift = 8'hFF;
			end else begin
				outShift = {outShift[6:0], 1'b1};
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/sdInitTb.sv
`timescale 1ns/1ps
`default_nettype none

module sdInitTb
	import sdInitPkg::*;
();

	localparam int ScenarioCount = 5;
	localparam int OutcomeTimeout = 50000; // The longest retry run needs about 20000 cycles

	// Card behavior and the outcome it must lead to
	typedef struct packed {
		logic badEcho;
		logic silent;
		logic [7:0] busyRounds;
		logic expReady;
		logic expFailed;
		logic [7:0] expCmd0;
		logic [7:0] expCmd8;
		logic [7:0] expCmd55;
		logic [7:0] expAcmd41;
	} scenario_t;

	logic clk = 1'b0;
	logic reset;
	logic cardAbsent;
	logic hostSck;
	logic hostCs;
	logic hostMosi;
	logic hostMiso;
	logic sdSck;
	logic sdCs;
	logic sdMosi;
	logic sdMiso;
	logic cardMiso;
	logic driveMiso; // Testbench owns MISO while the host pins are checked
	logic misoLevel;
	sdStatus_t status;
	logic badEcho;
	logic silent;
	logic [7:0] busyRounds;
	int cmd0Count;
	int cmd8Count;
	int cmd55Count;
	int acmd41Count;
	int crcErrors;
	int preClocks;
	scenario_t scenarios [ScenarioCount];

	always #2 clk = !clk;

	assign sdMiso = driveMiso ? misoLevel : cardMiso;

	sdInitTop uut (
		.clk(clk), .reset(reset), .cardAbsent(cardAbsent),
		.hostSck(hostSck), .hostCs(hostCs), .hostMosi(hostMosi), .hostMiso(hostMiso),
		.sdSck(sdSck), .sdCs(sdCs), .sdMosi(sdMosi), .sdMiso(sdMiso), .status(status)
	);

	sdCardModel card (
		.cardAbsent(cardAbsent), .badEcho(badEcho), .silent(silent), .busyRounds(busyRounds),
		.sdSck(sdSck), .sdCs(sdCs), .sdMosi(sdMosi), .sdMiso(cardMiso),
		.cmd0Count(cmd0Count), .cmd8Count(cmd8Count), .cmd55Count(cmd55Count),
		.acmd41Count(acmd41Count), .crcErrors(crcErrors), .preClocks(preClocks)
	);

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compareValue(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("Error at time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			stopRun("Stopping at the first mismatch");
		end
	endtask

	task automatic buildTable();
		logic [7:0] busy;
		logic [7:0] limit;
		busy = 8'($urandom_range(10, 1));
		limit = 8'(MaxInitRetries);
		// Columns are badEcho, silent, busyRounds, ready, failed, CMD0, CMD8, CMD55, ACMD41
		scenarios[0] = '{1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 8'd1, 8'd1, 8'd1, 8'd1};
		scenarios[1] = '{1'b0, 1'b0, busy, 1'b1, 1'b0, 8'd1, 8'd1, busy + 8'd1, busy + 8'd1};
		scenarios[2] = '{1'b0, 1'b0, limit + 8'd4, 1'b0, 1'b1, 8'd1, 8'd1, limit, limit};
		scenarios[3] = '{1'b1, 1'b0, 8'd0, 1'b0, 1'b1, 8'd1, 8'd1, 8'd0, 8'd0};
		scenarios[4] = '{1'b0, 1'b1, 8'd0, 1'b0, 1'b1, 8'd1, 8'd0, 8'd0, 8'd0}; // Silent card
	endtask

	task automatic waitForOutcome();
		int cycles;
		cycles = 0;
		while (!status.ready && !status.failed) begin
			if (cycles == OutcomeTimeout)
				stopRun("Timed out waiting for the start-up sequence to end");
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic applyScenario(input scenario_t row);
		@(negedge clk);
		badEcho = row.badEcho;
		silent = row.silent;
		busyRounds = row.busyRounds;
		cardAbsent = 1'b1; // Also resets the card model
		repeat (4) @(negedge clk);
		compareValue("status while absent", int'(status), 0);
		compareValue("sdCs while absent", int'(sdCs), 1);
		cardAbsent = 1'b0;
		waitForOutcome();
		compareValue("status.ready", int'(status.ready), int'(row.expReady));
		compareValue("status.failed", int'(status.failed), int'(row.expFailed));
		compareValue("CMD0 count", cmd0Count, int'(row.expCmd0));
		compareValue("CMD8 count", cmd8Count, int'(row.expCmd8));
		compareValue("CMD55 count", cmd55Count, int'(row.expCmd55));
		compareValue("ACMD41 count", acmd41Count, int'(row.expAcmd41));
		compareValue("CRC errors", crcErrors, 0);
		compareValue("preClocks >= 74", int'(preClocks >= 74), 1);
	endtask

	task automatic checkHostPins();
		logic [31:0] bits;
		repeat (16) begin
			@(negedge clk);
			bits = $urandom();
			hostSck = bits[0];
			hostCs = bits[1];
			hostMosi = bits[2];
			misoLevel = bits[3];
			driveMiso = 1'b1;
			@(posedge clk);
			compareValue("sdSck", int'(sdSck), int'(hostSck));
			compareValue("sdCs", int'(sdCs), int'(hostCs));
			compareValue("sdMosi", int'(sdMosi), int'(hostMosi));
			compareValue("hostMiso", int'(hostMiso), int'(misoLevel));
		end
		@(negedge clk);
		hostSck = 1'b0;
		hostCs = 1'b0; // Host keeps the card selected while it is pulled
		driveMiso = 1'b0;
		@(negedge clk);
		compareValue("sdCs before removal", int'(sdCs), 0);
		cardAbsent = 1'b1;
		@(negedge clk);
		compareValue("status after removal", int'(status), 0);
		compareValue("sdCs after removal", int'(sdCs), 1);
		cardAbsent = 1'b0;
		hostCs = 1'b1;
	endtask

	initial begin
		void'($urandom(32'hb90d81ba));
		reset = 1'b1;
		cardAbsent = 1'b0;
		hostSck = 1'b0;
		hostCs = 1'b1;
		hostMosi = 1'b1;
		driveMiso = 1'b0;
		misoLevel = 1'b1;
		badEcho = 1'b0;
		silent = 1'b0;
		busyRounds = 8'd0;
		buildTable();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int row = 0; row < ScenarioCount; row++) begin
			applyScenario(scenarios[row]);
			if (row == 0)
				checkHostPins(); // Pin hand-over is only live after ready
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sdInitTop.f
hw/sdInitPkg.sv
hw/spiByteShifter.sv
hw/sdCommandFramer.sv
hw/sdInitSequencer.sv
hw/sdInitTop.sv
verification/sdCardModel.sv
verification/sdInitTb.sv

//--- Makefile
# Verilator build for the SD card SPI start-up controller
VERILATOR ?= verilator
TOP ?= sdInitTb
FILELIST ?= sdInitTop.f
BUILD_DIR ?= build
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(wildcard hw/*.sv verification/*.sv)
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# A $fatal in the testbench makes the binary, and so this target, fail
run: compile
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
